// File: bench/tb_cdb_top.sv
// Testbench for the CDB writeback path
// Table rows post results from EU models, an ROB model checks order and data

`timescale 1ns/1ps

`include "cdb_macros.svh"

module tb_cdb_top;

    localparam int EU_N         = `CDB_EU_N;
    localparam int IDX_W        = `CDB_ROB_IDX_W;
    localparam int N_TAGS       = 1 << `CDB_ROB_IDX_W;
    localparam int N_ROWS       = 7;
    localparam int ROW_TIMEOUT  = 100;
    localparam int STALL_CYCLES = 12;
    localparam int FLUSH_AT     = 4;
    localparam int QUIET_CYCLES = 10;

    logic                  clk;
    logic                  rst_n;
    logic                  flush;
    logic [EU_N-1:0]       eu_valid;
    logic [EU_N-1:0]       eu_ready;
    expipe_pkg::cdb_data_t eu_data [EU_N];
    logic                  rob_ready;
    logic                  rob_valid;
    expipe_pkg::cdb_data_t rob_data;

    // Stimulus table, one row per step
    logic [EU_N-1:0]       row_mask      [N_ROWS];
    int                    row_reps      [N_ROWS];
    logic                  row_rand      [N_ROWS];
    logic                  row_rob_ready [N_ROWS];
    logic                  row_flush     [N_ROWS];
    // {except_raised, except_code}
    logic [2:0]            row_exc       [N_ROWS];
    logic [`CDB_XLEN-1:0]  row_value     [N_ROWS][EU_N];
    // Expected unit order at the ROB with nibble 0 leaving first
    logic [31:0]           row_order     [N_ROWS];
    int                    row_n_out     [N_ROWS];

    // Scoreboard indexed by ROB index
    logic                  pending  [N_TAGS];
    expipe_pkg::cdb_data_t tag_word [N_TAGS];
    int                    tag_unit [N_TAGS];
    int                    tag_iter [N_TAGS];

    // EU models
    logic                  cur_valid [EU_N];
    expipe_pkg::cdb_data_t cur_word  [EU_N];
    int                    left      [EU_N];
    int                    rep       [EU_N];
    int                    next_tag;
    logic [31:0]           rng_state;

    // Arbitration model with its pointer and the results not yet on the bus
    int                    rr_model;
    int                    mdl_left [EU_N];

    cdb_top u_cdb_top (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .flush_i     (flush),
        .eu_valid_i  (eu_valid),
        .eu_ready_o  (eu_ready),
        .eu_data_i   (eu_data),
        .rob_ready_i (rob_ready),
        .rob_valid_o (rob_valid),
        .rob_data_o  (rob_data)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic check_val(input string name, input logic [127:0] got,
                             input logic [127:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("TB FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    task automatic fail_now(input string reason);
        $display("error: %s", reason);
        $display("TB FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic set_row(input int r, input logic [EU_N-1:0] mask, input int reps,
                           input logic rnd, input logic rdy, input logic fl,
                           input logic [2:0] exc, input logic [31:0] order,
                           input int n_out);
        row_mask[r]      = mask;
        row_reps[r]      = reps;
        row_rand[r]      = rnd;
        row_rob_ready[r] = rdy;
        row_flush[r]     = fl;
        row_exc[r]       = exc;
        row_order[r]     = order;
        row_n_out[r]     = n_out;
    endtask

    task automatic set_values(input int r, input logic [`CDB_XLEN-1:0] v0,
                              input logic [`CDB_XLEN-1:0] v1,
                              input logic [`CDB_XLEN-1:0] v2,
                              input logic [`CDB_XLEN-1:0] v3);
        row_value[r][0] = v0;
        row_value[r][1] = v1;
        row_value[r][2] = v2;
        row_value[r][3] = v3;
    endtask

    task automatic build_table();
        // Lone unit 0 result with an exception for the latency check
        set_row(0, 4'b0001, 1, 1'b0, 1'b1, 1'b0, 3'b101, 32'h0000_0000, 1);
        set_values(0, 64'h0123_4567_89ab_cdef, 64'h0, 64'h0, 64'h0);
        // All units at once, unit 0 first
        set_row(1, 4'b1111, 1, 1'b0, 1'b1, 1'b0, 3'b000, 32'h0000_3210, 4);
        set_values(1, 64'h1000, 64'h1100, 64'h1200, 64'h1300);
        // Units 1 to 3 twice each
        set_row(2, 4'b1110, 2, 1'b0, 1'b1, 1'b0, 3'b000, 32'h0032_1321, 6);
        set_values(2, 64'h0, 64'h2100, 64'h2200, 64'h2300);
        // ROB stalled at first with random words
        set_row(3, 4'b1111, 2, 1'b1, 1'b0, 1'b0, 3'b000, 32'h3213_2100, 8);
        set_values(3, 64'h0, 64'h0, 64'h0, 64'h0);
        // Unit 2 alone leaves the pointer at unit 3
        set_row(4, 4'b0100, 1, 1'b0, 1'b1, 1'b0, 3'b110, 32'h0000_0002, 1);
        set_values(4, 64'h0, 64'h0, 64'h4200, 64'h0);
        // Flush with everything in flight
        set_row(5, 4'b1111, 1, 1'b0, 1'b0, 1'b1, 3'b000, 32'h0000_0000, 0);
        set_values(5, 64'h5000, 64'h5100, 64'h5200, 64'h5300);
        // Pointer back at unit 1 after the flush
        set_row(6, 4'b1110, 1, 1'b0, 1'b1, 1'b0, 3'b111, 32'h0000_0321, 3);
        set_values(6, 64'h0, 64'h6100, 64'h6200, 64'h6300);
    endtask

    function automatic expipe_pkg::cdb_data_t make_word(input int r, input int k,
                                                        input int j);
        expipe_pkg::cdb_data_t w;
        logic [31:0]           hi;
        logic [31:0]           lo;
        logic [31:0]           ex;
        w.rob_idx = IDX_W'(next_tag);
        if (row_rand[r]) begin
            hi = next_rand();
            lo = next_rand();
            ex = next_rand();
            w.value         = `CDB_XLEN'({hi, lo});
            w.except_raised = ex[2];
            w.except_code   = expipe_pkg::cdb_exc_e'(ex[1:0]);
        end else begin
            w.value         = row_value[r][k] + `CDB_XLEN'(j);
            w.except_raised = row_exc[r][2];
            w.except_code   = expipe_pkg::cdb_exc_e'(row_exc[r][1:0]);
        end
        return w;
    endfunction

    // Next word of an EU model, or idle when it has posted everything
    task automatic load_unit(input int r, input int k);
        if (left[k] > 0) begin
            cur_word[k]  = make_word(r, k, rep[k]);
            next_tag     = next_tag + 1;
            cur_valid[k] = 1'b1;
        end else begin
            cur_valid[k] = 1'b0;
        end
    endtask

    // Unit 0 first, then first unit with work at or after the pointer
    function automatic int model_next_unit();
        int u;
        int c;
        u = -1;
        if (mdl_left[0] > 0) begin
            u = 0;
        end else begin
            for (int i = 0; i < EU_N - 1; i++) begin
                c = 1 + (rr_model - 1 + i) % (EU_N - 1);
                if (u < 0 && mdl_left[c] > 0) begin
                    u = c;
                end
            end
            if (u > 0) begin
                rr_model = (u == EU_N - 1) ? 1 : u + 1;
            end
        end
        if (u >= 0) begin
            mdl_left[u] = mdl_left[u] - 1;
        end
        return u;
    endfunction

    initial begin
        int                    iter;
        int                    out_cnt;
        int                    tag;
        int                    exp_unit;
        logic [EU_N-1:0]       acc;
        logic [EU_N-1:0]       rdy_smp;
        logic                  fire;
        logic                  stall;
        logic                  hold_prev;
        logic                  flush_seen;
        logic                  done;
        expipe_pkg::cdb_data_t word;
        expipe_pkg::cdb_data_t held;

        rst_n     = 1'b0;
        flush     = 1'b0;
        eu_valid  = '0;
        rob_ready = 1'b0;
        for (int k = 0; k < EU_N; k++) begin
            eu_data[k]   = '0;
            cur_valid[k] = 1'b0;
        end
        for (int t = 0; t < N_TAGS; t++) begin
            pending[t] = 1'b0;
        end
        rng_state = 32'd19;
        next_tag  = 0;
        rr_model  = 1;
        build_table();

        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_val("rob_valid_o after reset", 128'(rob_valid), 128'(0));

        for (int r = 0; r < N_ROWS; r++) begin
            for (int k = 0; k < EU_N; k++) begin
                left[k]     = row_mask[r][k] ? row_reps[r] : 0;
                mdl_left[k] = left[k];
                rep[k]      = 0;
                load_unit(r, k);
            end
            iter       = 0;
            out_cnt    = 0;
            hold_prev  = 1'b0;
            flush_seen = 1'b0;
            done       = 1'b0;
            while (!done) begin
                if (iter >= ROW_TIMEOUT) begin
                    fail_now($sformatf("timeout waiting for row %0d to reach the ROB", r));
                end
                // ROB stalls until the flush, or for the first cycles of a stall row
                if (row_flush[r]) begin
                    stall = ~flush_seen;
                end else begin
                    stall = ~row_rob_ready[r] && (iter < STALL_CYCLES);
                end
                for (int k = 0; k < EU_N; k++) begin
                    eu_valid[k] = cur_valid[k];
                    eu_data[k]  = cur_word[k];
                end
                rob_ready = ~stall;
                flush     = row_flush[r] && (iter == FLUSH_AT);

                // Sample handshakes just before the edge
                #6;
                acc     = eu_valid & eu_ready;
                rdy_smp = eu_ready;
                fire    = rob_valid & rob_ready;
                word    = rob_data;
                if (rob_valid && !rob_ready) begin
                    if (hold_prev) begin
                        check_val("rob_data_o under stall", 128'(rob_data), 128'(held));
                    end
                    held      = rob_data;
                    hold_prev = 1'b1;
                end else begin
                    hold_prev = 1'b0;
                end

                @(posedge clk);
                #1;
                for (int k = 0; k < EU_N; k++) begin
                    if (acc[k]) begin
                        tag           = int'(cur_word[k].rob_idx);
                        pending[tag]  = ~flush;
                        tag_word[tag] = cur_word[k];
                        tag_unit[tag] = k;
                        tag_iter[tag] = iter;
                        left[k]       = left[k] - 1;
                        rep[k]        = rep[k] + 1;
                        load_unit(r, k);
                    end
                end
                if (fire) begin
                    tag = int'(word.rob_idx);
                    if (!pending[tag]) begin
                        fail_now($sformatf("ROB got rob_idx 0x%0h that is not in flight", tag));
                    end
                    pending[tag] = 1'b0;
                    check_val("rob_data_o", 128'(word), 128'(tag_word[tag]));
                    exp_unit = int'(row_order[r][4*out_cnt +: 4]);
                    check_val("served unit", 128'(tag_unit[tag]), 128'(exp_unit));
                    check_val("round-robin unit", 128'(tag_unit[tag]),
                              128'(model_next_unit()));
                    if (r == 0) begin
                        check_val("latency", 128'(iter - tag_iter[tag]), 128'(2));
                    end
                    out_cnt = out_cnt + 1;
                end
                if (flush) begin
                    check_val("rob_valid_o after flush", 128'(rob_valid), 128'(0));
                    for (int t = 0; t < N_TAGS; t++) begin
                        pending[t] = 1'b0;
                    end
                    for (int k = 0; k < EU_N; k++) begin
                        mdl_left[k] = 0;
                    end
                    rr_model   = 1;
                    flush_seen = 1'b1;
                end
                // Full output register blocks every grant, so every slot is full by now
                if (!row_rob_ready[r] && !row_flush[r] && iter == STALL_CYCLES - 1) begin
                    check_val("eu_ready_o under stall", 128'(rdy_smp), 128'(0));
                end

                iter = iter + 1;
                if (row_flush[r]) begin
                    done = (iter >= FLUSH_AT + 1 + QUIET_CYCLES);
                end else begin
                    done = (out_cnt == row_n_out[r]);
                    for (int k = 0; k < EU_N; k++) begin
                        if (left[k] > 0) begin
                            done = 1'b0;
                        end
                    end
                end
            end
        end

        eu_valid = '0;
        flush    = 1'b0;
        $display("TB PASSED");
        $finish;
    end

endmodule

// File: compile.f
+incdir+hdl
hdl/expipe_pkg.sv
hdl/eu_result_slot.sv
hdl/cdb_arbiter.sv
hdl/cdb.sv
hdl/cdb_out_reg.sv
hdl/cdb_top.sv
bench/tb_cdb_top.sv

// File: hdl/cdb.sv
// Common data bus stage
// Arbitrates among the result slots and muxes the served word onto the bus

`timescale 1ns/1ps

`include "cdb_macros.svh"

module cdb (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // From the result slots, unit 0 is maximum priority
    input  logic [`CDB_EU_N-1:0]  slot_valid_i,
    output logic [`CDB_EU_N-1:0]  slot_ready_o,
    input  expipe_pkg::cdb_data_t slot_data_i [`CDB_EU_N],

    // Toward the output register
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output expipe_pkg::cdb_data_t out_data_o
);

    localparam int IDX_W = $clog2(`CDB_EU_N);

    // Low priority word picked by the round-robin select
    expipe_pkg::cdb_data_t low_prio_data;

    // Arbiter decision
    logic                  served_max_prio;
    logic [IDX_W-1:0]      served;

    cdb_arbiter #(
        .EU_N  (`CDB_EU_N),
        .IDX_W (IDX_W)
    ) u_cdb_arbiter (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .flush_i           (flush_i),
        .max_prio_valid_i  (slot_valid_i[0]),
        .max_prio_ready_o  (slot_ready_o[0]),
        .valid_i           (slot_valid_i[`CDB_EU_N-1:1]),
        .ready_o           (slot_ready_o[`CDB_EU_N-1:1]),
        .out_ready_i       (out_ready_i),
        .out_valid_o       (out_valid_o),
        .served_max_prio_o (served_max_prio),
        .served_o          (served)
    );

    // First level, low priority select
    assign low_prio_data = slot_data_i[served];

    // Second level, unit 0 overrides
    assign out_data_o = served_max_prio ? slot_data_i[0] : low_prio_data;

endmodule

// File: hdl/cdb_arbiter.sv
// CDB arbiter
// Unit 0 always wins when valid, the other units share the bus
// round-robin from a registered pointer

`timescale 1ns/1ps

`include "cdb_macros.svh"

module cdb_arbiter #(
    parameter int EU_N  = `CDB_EU_N,
    parameter int IDX_W = $clog2(`CDB_EU_N)
) (
    input  logic             clk_i,
    input  logic             rst_n_i,
    input  logic             flush_i,

    // Maximum priority unit
    input  logic             max_prio_valid_i,
    output logic             max_prio_ready_o,

    // Low priority units 1 to EU_N-1
    input  logic [EU_N-1:1]  valid_i,
    output logic [EU_N-1:1]  ready_o,

    // Toward the output register
    input  logic             out_ready_i,
    output logic             out_valid_o,

    // Selected unit for the data mux
    output logic             served_max_prio_o,
    output logic [IDX_W-1:0] served_o
);

    // Round-robin pointer, always in 1..EU_N-1
    logic [IDX_W-1:0] rr_ptr;
    // First valid low priority unit at or after the pointer
    logic [IDX_W-1:0] lp_sel;
    logic             lp_found;
    // Pointer value after serving lp_sel
    logic [IDX_W-1:0] lp_next;
    // A low priority unit transfers this cycle
    logic             lp_served;

    // Circular search over units 1..EU_N-1
    always_comb begin
        int cand;
        lp_found = 1'b0;
        lp_sel   = IDX_W'(1);
        for (int i = 0; i < EU_N - 1; i++) begin
            cand = int'(rr_ptr) + i;
            // Wrap past the last unit, skipping unit 0
            if (cand >= EU_N) begin
                cand = cand - (EU_N - 1);
            end
            if (!lp_found && valid_i[cand]) begin
                lp_found = 1'b1;
                lp_sel   = IDX_W'(cand);
            end
        end
    end

    assign lp_next = (int'(lp_sel) == EU_N - 1) ? IDX_W'(1) : lp_sel + IDX_W'(1);

    // Grants only while the output register can take a word
    assign max_prio_ready_o = out_ready_i & max_prio_valid_i;
    assign lp_served        = out_ready_i & ~max_prio_valid_i & lp_found;

    always_comb begin
        for (int k = 1; k < EU_N; k++) begin
            ready_o[k] = lp_served && (int'(lp_sel) == k);
        end
    end

    // Something is on the bus whenever any unit is valid
    assign out_valid_o       = max_prio_valid_i | lp_found;
    assign served_max_prio_o = max_prio_valid_i;
    assign served_o          = lp_sel;

    // Pointer moves only when a low priority unit is served
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rr_ptr <= IDX_W'(1);
        end else if (flush_i) begin
            rr_ptr <= IDX_W'(1);
        end else if (lp_served) begin
            rr_ptr <= lp_next;
        end
    end

endmodule

// File: hdl/cdb_macros.svh
// CDB writeback path parameters
// Result width, execution unit count and ROB index width

`ifndef CDB_MACROS_SVH
`define CDB_MACROS_SVH

// Width of a result value
`define CDB_XLEN 64

// Number of execution units
// Unit 0 is the load/store unit with maximum priority
// At least 2 units
`define CDB_EU_N 4

// Width of a reorder buffer index
`define CDB_ROB_IDX_W 5

`endif

// File: hdl/cdb_out_reg.sv
// CDB output register
// Registers the bus word toward the ROB, holds it stable under back-pressure

`timescale 1ns/1ps

`include "cdb_macros.svh"

module cdb_out_reg (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // From the CDB
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  expipe_pkg::cdb_data_t in_data_i,

    // Toward the ROB
    input  logic                  rob_ready_i,
    output logic                  rob_valid_o,
    output expipe_pkg::cdb_data_t rob_data_o
);

    logic                  valid_q;
    expipe_pkg::cdb_data_t data_q;
    // New word captured this cycle
    logic                  load;
    // Held word leaves toward the ROB this cycle
    logic                  drain;

    // Can refill in the same cycle the ROB takes the old word
    assign in_ready_o = ~valid_q | rob_ready_i;
    assign load       = in_valid_i & in_ready_o;
    assign drain      = valid_q & rob_ready_i;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= 1'b0;
        end else if (load || drain) begin
            // Stays set on a refill, clears on a plain drain
            valid_q <= load;
        end
    end

    // Payload only changes on load, so it is stable while stalled
    always_ff @(posedge clk_i) begin
        if (load) begin
            data_q <= in_data_i;
        end
    end

    assign rob_valid_o = valid_q;
    assign rob_data_o  = data_q;

endmodule

// File: hdl/cdb_top.sv
// CDB writeback path top level
// Result slots per EU, then CDB arbitration and mux, then ROB output register

`timescale 1ns/1ps

`include "cdb_macros.svh"

module cdb_top (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // Execution units
    input  logic [`CDB_EU_N-1:0]  eu_valid_i,
    output logic [`CDB_EU_N-1:0]  eu_ready_o,
    input  expipe_pkg::cdb_data_t eu_data_i [`CDB_EU_N],

    // Reorder buffer
    input  logic                  rob_ready_i,
    output logic                  rob_valid_o,
    output expipe_pkg::cdb_data_t rob_data_o
);

    // Slot to CDB
    logic [`CDB_EU_N-1:0]  slot_valid;
    logic [`CDB_EU_N-1:0]  cdb_ready;
    expipe_pkg::cdb_data_t slot_data [`CDB_EU_N];

    // CDB to output register
    logic                  cdb_valid;
    logic                  oreg_ready;
    expipe_pkg::cdb_data_t cdb_data;

    // One result slot per execution unit
    for (genvar k = 0; k < `CDB_EU_N; k++) begin : g_slot
        eu_result_slot u_eu_result_slot (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .flush_i     (flush_i),
            .in_valid_i  (eu_valid_i[k]),
            .in_ready_o  (eu_ready_o[k]),
            .in_data_i   (eu_data_i[k]),
            .out_valid_o (slot_valid[k]),
            .out_ready_i (cdb_ready[k]),
            .out_data_o  (slot_data[k])
        );
    end

    cdb u_cdb (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .slot_valid_i (slot_valid),
        .slot_ready_o (cdb_ready),
        .slot_data_i  (slot_data),
        .out_valid_o  (cdb_valid),
        .out_ready_i  (oreg_ready),
        .out_data_o   (cdb_data)
    );

    cdb_out_reg u_cdb_out_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .in_valid_i  (cdb_valid),
        .in_ready_o  (oreg_ready),
        .in_data_i   (cdb_data),
        .rob_ready_i (rob_ready_i),
        .rob_valid_o (rob_valid_o),
        .rob_data_o  (rob_data_o)
    );

endmodule

// File: hdl/eu_result_slot.sv
// EU result slot
// One-entry buffer between an execution unit and the CDB

`timescale 1ns/1ps

`include "cdb_macros.svh"

module eu_result_slot (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  logic                  flush_i,

    // From the execution unit
    input  logic                  in_valid_i,
    output logic                  in_ready_o,
    input  expipe_pkg::cdb_data_t in_data_i,

    // Toward the CDB
    output logic                  out_valid_o,
    input  logic                  out_ready_i,
    output expipe_pkg::cdb_data_t out_data_o
);

    // Occupancy flag
    logic                  full;
    // Held result
    expipe_pkg::cdb_data_t data_q;

    // Free when empty or when the CDB takes the held word now
    assign in_ready_o = ~full | out_ready_i;

    // Control state
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            full <= 1'b0;
        end else if (flush_i) begin
            // Flush wins over any transfer
            full <= 1'b0;
        end else if (in_valid_i && in_ready_o) begin
            full <= 1'b1;
        end else if (out_ready_i) begin
            full <= 1'b0;
        end
    end

    // Payload capture on accept
    always_ff @(posedge clk_i) begin
        if (in_valid_i && in_ready_o) begin
            data_q <= in_data_i;
        end
    end

    assign out_valid_o = full;
    assign out_data_o  = data_q;

endmodule

// File: hdl/expipe_pkg.sv
// Execution pipeline types
// Bus word carried on the CDB and the exception causes it can flag

`include "cdb_macros.svh"

package expipe_pkg;

    // Exception cause attached to a result
    typedef enum logic [1:0] {
        CDB_EXC_NONE         = 2'd0,
        CDB_EXC_MISALIGNED   = 2'd1,
        CDB_EXC_ACCESS_FAULT = 2'd2,
        CDB_EXC_ILLEGAL      = 2'd3
    } cdb_exc_e;

    // One CDB word
    // ROB entry tag, result value and exception info
    typedef struct packed {
        // Destination ROB entry
        logic [`CDB_ROB_IDX_W-1:0] rob_idx;
        // Result produced by the EU
        logic [`CDB_XLEN-1:0]      value;
        // Set when the instruction raised an exception
        logic                      except_raised;
        // Cause, only meaningful with except_raised
        cdb_exc_e                  except_code;
    } cdb_data_t;

endpackage

// File: run_sim.sh
#!/bin/sh
# Build and run the CDB writeback testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps -f compile.f \
    --top-module tb_cdb_top -o tb_cdb_top_sim

out=$(./obj_dir/tb_cdb_top_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
